//--- backend_top.f
core_pkg.sv
stage_if.sv
exec_stage.sv
ex_mem.sv
mem_stage.sv
backend_top.sv
tb_backend_top.sv

//--- tb_backend_top.sv
// Random instruction stream for backend_top, checked against a model with its own RAM copy.
// The first 64 instructions are sd to every RAM word, so no load reads an unwritten word.
// Stalls start after the first 150 instructions and last at most MAX_STALL cycles in a row.
`timescale 1ns/1ns

module tb_backend_top;
    import core_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int N_INSTR     = 400;
    localparam int N_INIT      = 64;
    localparam int N_CALM      = 150;
    localparam int MAX_STALL   = 3;
    localparam int WATCHDOG_NS = (N_INSTR + 20) * 2 * (MAX_STALL + 1) * CLK_PERIOD;

    typedef struct packed {
        logic        ena;
        reg_addr_t   addr;
        xlen_t       data;
        pc_t         pc;
        inst_t       inst;
        logic [31:0] edge_no;
        logic [31:0] stalls;
    } exp_t;

    logic      clk, rst_n_i, stall_i, valid_i;
    pc_t       pc_i, wb_pc_o;
    inst_t     inst_i, wb_inst_o;
    xlen_t     rs1_data_i, rs2_data_i, wb_rd_data_o;
    logic      wb_valid_o, wb_rd_ena_o;
    reg_addr_t wb_rd_addr_o;

    xlen_t       model_mem [64];               // byte address bits 8:3 pick the word.
    exp_t        exp_q [$];
    exp_t        pend;
    logic [31:0] lcg_state = 32'ha7bc;
    int          issued, accepted, edge_cnt, stall_cnt, stall_run, value_errs, other_errs;
    xlen_t       last_word;                    // word touched by the latest store.
    pc_t         next_pc = 64'h1000;
    logic        held = 1'b0;                  // the previous edge was stalled.
    logic        hold_valid, hold_ena;
    reg_addr_t   hold_addr;
    xlen_t       hold_data;
    pc_t         hold_pc;
    inst_t       hold_inst;

    backend_top #(.RAM_DEPTH(64)) backend_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the pipeline stopped producing results.");
        $display("=== FAIL ===");
        $finish;
    end

    // ============================================================
    // random numbers, encoders and reference model
    // ============================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    function automatic xlen_t rand64();
        xlen_t v;
        v[63:32] = lcg_next();
        v[31:0]  = lcg_next();
        return v;
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                    logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic xlen_t alu_model(logic [2:0] f3, logic alt, xlen_t x, xlen_t y);
        case (f3)
            F3_ADD:  return alt ? x - y : x + y;
            F3_SLL:  return x << y[5:0];
            F3_SLT:  return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            F3_XOR:  return x ^ y;
            F3_SR:   return x >> y[5:0];
            F3_OR:   return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic xlen_t load_model(xlen_t addr, ls_sel_t sel);
        xlen_t w;
        int    bits;
        w    = model_mem[addr[8:3]] >> (8 * addr[2:0]);
        bits = 8 << sel[1:0];
        if (bits < 64) begin
            w = w & ((64'd1 << bits) - 1);
            if (!sel[2] && w[bits-1]) w = w | ~((64'd1 << bits) - 1);   // signed loads.
        end
        return w;
    endfunction

    task automatic store_model(xlen_t addr, xlen_t data, ls_sel_t sel);
        for (int i = 0; i < (1 << sel[1:0]); i++) begin
            model_mem[addr[8:3]][8 * (addr[2:0] + i) +: 8] = data[8 * i +: 8];
        end
    endtask

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
        $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        value_errs++;
    endtask

    task automatic check_data(string name, xlen_t got, xlen_t exp);
        if (got !== exp) value_error(name, got, exp);
    endtask

    task automatic check_reg_addr(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) value_error(name, got, exp);
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) value_error(name, got, exp);
    endtask

    task automatic check_inst(string name, inst_t got, inst_t exp);
        if (got !== exp) value_error(name, got, exp);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) value_error(name, got, exp);
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    task automatic gen_instr();
        reg_addr_t   rd, rs1, rs2;
        xlen_t       a, b, res;
        inst_t       ins;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt, wr;
        int          kind;
        rd   = (rand_below(8) == 0) ? 5'd0 : reg_addr_t'(lcg_next() >> 11);
        rs1  = reg_addr_t'(lcg_next() >> 11);
        rs2  = reg_addr_t'(lcg_next() >> 11);
        a    = rand64();
        b    = rand64();
        imm  = 12'(lcg_next() >> 9);
        f3   = 3'(rand_below(7));
        f3   = (f3 >= 3'd3) ? f3 + 3'd1 : f3;     // sltu is outside the subset.
        alt  = (f3 == F3_ADD) && (rand_below(2) == 0);
        wr   = 1'b1;
        res  = '0;
        kind = (issued < N_INIT) ? 8 : rand_below(10);
        case (kind)
            0, 1, 2: begin
                ins = enc_r(alt ? F7_ALT : F7_BASE, f3, rd, rs1, rs2);
                res = alu_model(f3, alt, a, b);
            end
            3, 4: begin
                f3  = (f3 == F3_SLL || f3 == F3_SR) ? F3_ADD : f3;
                ins = enc_i(OPC_OP_IMM, f3, rd, rs1, imm);
                res = alu_model(f3, 1'b0, a, {{52{imm[11]}}, imm});
            end
            5: begin
                ins = {b[19:0], rd, OPC_LUI};
                res = {{32{b[19]}}, b[19:0], 12'h000};
            end
            6, 7: begin
                f3  = 3'(rand_below(7));
                a   = xlen_t'(rand_below(16) * 8);
                imm = 12'(rand_below(8) << f3[1:0]);
                if (rand_below(2) == 0) begin   // read back the latest store.
                    a   = last_word;
                    imm = '0;
                end
                ins = enc_i(OPC_LOAD, f3, rd, rs1, imm);
                res = load_model(a + imm, f3);
            end
            8: begin
                f3  = 3'(rand_below(4));
                a   = xlen_t'(rand_below(16) * 8);
                imm = 12'(rand_below(8) << f3[1:0]);
                if (issued < N_INIT) begin
                    a   = '0;
                    imm = 12'(issued * 8);
                    f3  = LS_D;
                end
                ins       = enc_s(f3, rs1, rs2, imm);
                store_model(a + imm, b, f3);
                last_word = (a + imm) & ~64'd7;
                wr        = 1'b0;
            end
            default: begin                       // slli or a branch, neither is decoded.
                ins = enc_i(OPC_OP_IMM, F3_SLL, rd, rs1, imm);
                if (rand_below(2) == 0) ins[6:0] = 7'b1100011;
                wr  = 1'b0;
            end
        endcase
        pend.ena   = wr && (rd != 5'd0);
        pend.addr  = rd;
        pend.data  = res;
        pend.pc    = next_pc;
        pend.inst  = ins;
        inst_i     <= ins;
        pc_i       <= next_pc;
        rs1_data_i <= a;
        rs2_data_i <= b;
        valid_i    <= 1'b1;
        next_pc    = next_pc + 4;
        issued++;
    endtask

    // one clock edge: check the wb outputs, record an accepted instruction, drive new inputs.
    task automatic step(bit allow_issue);
        exp_t e;
        @(posedge clk);
        edge_cnt++;
        if (stall_i) stall_cnt++;
        if (held) begin                          // a stalled edge must leave wb unchanged.
            check_bit("wb_valid_o", wb_valid_o, hold_valid);
            check_bit("wb_rd_ena_o", wb_rd_ena_o, hold_ena);
            check_reg_addr("wb_rd_addr_o", wb_rd_addr_o, hold_addr);
            check_data("wb_rd_data_o", wb_rd_data_o, hold_data);
            check_pc("wb_pc_o", wb_pc_o, hold_pc);
            check_inst("wb_inst_o", wb_inst_o, hold_inst);
        end
        held       = stall_i;
        hold_valid = wb_valid_o;
        hold_ena   = wb_rd_ena_o;
        hold_addr  = wb_rd_addr_o;
        hold_data  = wb_rd_data_o;
        hold_pc    = wb_pc_o;
        hold_inst  = wb_inst_o;
        if (wb_valid_o && exp_q.size() == 0) begin
            $display("Unexpected result at %0t: wb_valid_o is high with nothing in flight.",
                     $time);
            other_errs++;
        end else if (wb_valid_o) begin
            e = exp_q[0];
            check_bit("wb_rd_ena_o", wb_rd_ena_o, e.ena);
            check_pc("wb_pc_o", wb_pc_o, e.pc);
            check_inst("wb_inst_o", wb_inst_o, e.inst);
            if (e.ena) begin
                check_reg_addr("wb_rd_addr_o", wb_rd_addr_o, e.addr);
                check_data("wb_rd_data_o", wb_rd_data_o, e.data);
            end
            if (!stall_i) begin
                if (edge_cnt - e.edge_no != 2 + stall_cnt - e.stalls) begin
                    $display("Latency wrong at %0t: result for pc %0h came %0d edges late.",
                             $time, e.pc, edge_cnt - e.edge_no);
                    other_errs++;
                end
                e = exp_q.pop_front();
            end
        end else begin
            check_bit("wb_rd_ena_o", wb_rd_ena_o, 1'b0);
        end
        if (valid_i && !stall_i) begin
            pend.edge_no = edge_cnt;
            pend.stalls  = stall_cnt;
            exp_q.push_back(pend);
            accepted++;
        end
        if (!stall_i) begin
            if (allow_issue && issued < N_INSTR && rand_below(8) != 0) gen_instr();
            else valid_i <= 1'b0;
        end
        if (allow_issue && issued > N_CALM && stall_run < MAX_STALL && rand_below(5) == 0) begin
            stall_i <= 1'b1;
            stall_run++;
        end else begin
            stall_i   <= 1'b0;
            stall_run = 0;
        end
    endtask

    initial begin
        rst_n_i    = 1'b0;
        stall_i    = 1'b0;
        valid_i    = 1'b0;
        pc_i       = '0;
        inst_i     = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (4) step(1'b0);                   // idle, nothing may come out.
        while (accepted < N_INSTR) step(1'b1);
        repeat (4) step(1'b0);
        if (exp_q.size() != 0) begin
            $display("Missing results: %0d accepted instructions never reached writeback.",
                     exp_q.size());
            other_errs++;
        end
        $display("Summary: %0d instructions, %0d value errors, %0d other errors",
                 accepted, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- backend_top.sv
// Back end of a small in-order RV64I pipeline: execute, ex_mem, memory.
// Results appear on the wb outputs two edges after acceptance when not stalled.
// While stall_i is high the caller must hold valid_i, pc_i, inst_i and operands.
`timescale 1ns/1ns

module backend_top #(
    parameter int RAM_DEPTH = 64
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 valid_i,
    input  core_pkg::pc_t        pc_i,
    input  core_pkg::inst_t      inst_i,
    input  core_pkg::xlen_t      rs1_data_i,
    input  core_pkg::xlen_t      rs2_data_i,
    output logic                 wb_valid_o,
    output logic                 wb_rd_ena_o,
    output core_pkg::reg_addr_t  wb_rd_addr_o,
    output core_pkg::xlen_t      wb_rd_data_o,
    output core_pkg::pc_t        wb_pc_o,
    output core_pkg::inst_t      wb_inst_o
);

    stage_if ex_bus ();
    stage_if mem_bus ();

    exec_stage exec_stage_inst (
        .valid_i    (valid_i),
        .pc_i       (pc_i),
        .inst_i     (inst_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ex_o       (ex_bus.src)
    );

    ex_mem ex_mem_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .ex_i    (ex_bus.dst),
        .mem_o   (mem_bus.src)
    );

    mem_stage #(
        .RAM_DEPTH (RAM_DEPTH)
    ) mem_stage_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .mem_i        (mem_bus.dst),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_ena_o  (wb_rd_ena_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o),
        .wb_pc_o      (wb_pc_o),
        .wb_inst_o    (wb_inst_o)
    );

endmodule

//--- mem_stage.sv
// Memory stage with an internal data RAM and the writeback register.
// RAM_DEPTH must be a power of two of at least 2. Addresses wrap in the RAM
// and misaligned accesses are not checked. The RAM itself has no reset.
// A store held by a stall rewrites the same bytes on every stalled cycle.
`timescale 1ns/1ns

module mem_stage #(
    parameter int RAM_DEPTH = 64
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    stage_if.dst                 mem_i,
    output logic                 wb_valid_o,
    output logic                 wb_rd_ena_o,
    output core_pkg::reg_addr_t  wb_rd_addr_o,
    output core_pkg::xlen_t      wb_rd_data_o,
    output core_pkg::pc_t        wb_pc_o,
    output core_pkg::inst_t      wb_inst_o
);
    import core_pkg::*;

    localparam int NBYTES = XLEN / 8;
    localparam int OFF_W  = $clog2(NBYTES);
    localparam int IDX_W  = $clog2(RAM_DEPTH);

    xlen_t              ram [RAM_DEPTH];
    logic [OFF_W-1:0]   byte_off;
    logic [IDX_W-1:0]   word_idx;
    logic [NBYTES-1:0]  size_mask;
    logic [NBYTES-1:0]  wr_mask;
    xlen_t              wr_data;
    xlen_t              rd_word;
    xlen_t              load_data;

    assign byte_off = mem_i.ls_addr[OFF_W-1:0];
    assign word_idx = mem_i.ls_addr[OFF_W +: IDX_W];   // upper bits wrap.

    // ============================================================
    // byte-masked store
    // ============================================================
    always_comb begin
        case (mem_i.ls_sel)
            LS_B:    size_mask = 8'h01;
            LS_H:    size_mask = 8'h03;
            LS_W:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign wr_mask = size_mask << byte_off;
    assign wr_data = mem_i.store_data << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (mem_i.valid && mem_i.op == OP_STORE) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (wr_mask[b]) ram[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // ============================================================
    // load extraction
    // ============================================================
    assign rd_word = ram[word_idx] >> {byte_off, 3'b000};   // selected bytes land at bit 0.

    always_comb begin
        case (mem_i.ls_sel)
            LS_B:    load_data = {{(XLEN-8){rd_word[7]}}, rd_word[7:0]};
            LS_H:    load_data = {{(XLEN-16){rd_word[15]}}, rd_word[15:0]};
            LS_W:    load_data = {{(XLEN-32){rd_word[31]}}, rd_word[31:0]};
            LS_BU:   load_data = {{(XLEN-8){1'b0}}, rd_word[7:0]};
            LS_HU:   load_data = {{(XLEN-16){1'b0}}, rd_word[15:0]};
            LS_WU:   load_data = {{(XLEN-32){1'b0}}, rd_word[31:0]};
            default: load_data = rd_word;
        endcase
    end

    // writeback register, frozen by a stall like ex_mem.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o   <= 1'b0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
        end else if (!stall_i) begin
            wb_valid_o   <= mem_i.valid;
            wb_rd_ena_o  <= mem_i.rd_ena;
            wb_rd_addr_o <= mem_i.rd_addr;
            wb_rd_data_o <= (mem_i.op == OP_LOAD) ? load_data : mem_i.rd_data;
            wb_pc_o      <= mem_i.pc;
            wb_inst_o    <= mem_i.inst;
        end
    end

endmodule

//--- ex_mem.sv
// Pipeline register between the execute and memory stages.
// A stall holds every field; the upstream producer must keep its inputs steady.
`timescale 1ns/1ns

module ex_mem (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   stall_i,
    stage_if.dst   ex_i,
    stage_if.src   mem_o
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_o.valid      <= 1'b0;
            mem_o.op         <= OP_NONE;
            mem_o.rd_ena     <= 1'b0;
            mem_o.rd_addr    <= '0;
            mem_o.rd_data    <= '0;
            mem_o.ls_sel     <= '0;
            mem_o.ls_addr    <= '0;
            mem_o.store_data <= '0;
            mem_o.pc         <= '0;
            mem_o.inst       <= '0;
        end else if (!stall_i) begin
            mem_o.valid      <= ex_i.valid;
            mem_o.op         <= ex_i.op;
            mem_o.rd_ena     <= ex_i.rd_ena;
            mem_o.rd_addr    <= ex_i.rd_addr;
            mem_o.rd_data    <= ex_i.rd_data;
            mem_o.ls_sel     <= ex_i.ls_sel;
            mem_o.ls_addr    <= ex_i.ls_addr;
            mem_o.store_data <= ex_i.store_data;
            mem_o.pc         <= ex_i.pc;
            mem_o.inst       <= ex_i.inst;
        end
    end

endmodule

//--- exec_stage.sv
// Combinational decode and execute for a subset of RV64I.
// Encodings outside the subset leave op at none and never write a register.
// Operands come from an upstream register file; there is no forwarding.
`timescale 1ns/1ns

module exec_stage (
    input  logic              valid_i,
    input  core_pkg::pc_t     pc_i,
    input  core_pkg::inst_t   inst_i,
    input  core_pkg::xlen_t   rs1_data_i,
    input  core_pkg::xlen_t   rs2_data_i,
    stage_if.src              ex_o
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    op_e        op;
    logic       writes_rd;
    xlen_t      alu_res;
    xlen_t      ls_addr;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    // ============================================================
    // decode and execute
    // ============================================================
    always_comb begin
        op        = OP_NONE;
        writes_rd = 1'b0;
        alu_res   = '0;
        ls_addr   = '0;
        case (opcode)
            OPC_LUI: begin
                op      = OP_ALU;
                alu_res = imm_u;
            end
            OPC_OP_IMM: begin
                op = OP_ALU;
                case (funct3)
                    F3_ADD:  alu_res = rs1_data_i + imm_i;
                    F3_SLT:  alu_res = xlen_t'($signed(rs1_data_i) < $signed(imm_i));
                    F3_XOR:  alu_res = rs1_data_i ^ imm_i;
                    F3_OR:   alu_res = rs1_data_i | imm_i;
                    F3_AND:  alu_res = rs1_data_i & imm_i;
                    default: op = OP_NONE;    // shifts and sltiu are not decoded.
                endcase
            end
            OPC_OP: begin
                op = OP_ALU;
                if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    alu_res = rs1_data_i - rs2_data_i;
                end else if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  alu_res = rs1_data_i + rs2_data_i;
                        F3_SLL:  alu_res = rs1_data_i << rs2_data_i[5:0];
                        F3_SLT:  alu_res = xlen_t'($signed(rs1_data_i) < $signed(rs2_data_i));
                        F3_XOR:  alu_res = rs1_data_i ^ rs2_data_i;
                        F3_SR:   alu_res = rs1_data_i >> rs2_data_i[5:0];
                        F3_OR:   alu_res = rs1_data_i | rs2_data_i;
                        F3_AND:  alu_res = rs1_data_i & rs2_data_i;
                        default: op = OP_NONE;
                    endcase
                end else begin
                    op = OP_NONE;
                end
            end
            OPC_LOAD: begin
                if (funct3 <= LS_WU) begin
                    op      = OP_LOAD;
                    ls_addr = rs1_data_i + imm_i;
                end
            end
            OPC_STORE: begin
                if (funct3 <= LS_D) begin
                    op      = OP_STORE;
                    ls_addr = rs1_data_i + imm_s;
                end
            end
            default: op = OP_NONE;
        endcase
        writes_rd = (op == OP_ALU) || (op == OP_LOAD);
    end

    assign ex_o.valid      = valid_i;
    assign ex_o.op         = op;
    assign ex_o.rd_ena     = valid_i && writes_rd && (rd != '0);   // x0 is never written.
    assign ex_o.rd_addr    = rd;
    assign ex_o.rd_data    = alu_res;
    assign ex_o.ls_sel     = funct3;
    assign ex_o.ls_addr    = ls_addr;
    assign ex_o.store_data = rs2_data_i;
    assign ex_o.pc         = pc_i;
    assign ex_o.inst       = inst_i;

endmodule

//--- stage_if.sv
// One instruction's execute results on their way to the memory stage.
// The bundle carries no handshake of its own; the stall input freezes it.
`timescale 1ns/1ns

interface stage_if;
    import core_pkg::*;

    logic      valid;
    op_e       op;
    logic      rd_ena;
    reg_addr_t rd_addr;
    xlen_t     rd_data;      // alu result.
    ls_sel_t   ls_sel;
    xlen_t     ls_addr;      // byte address for loads and stores.
    xlen_t     store_data;
    pc_t       pc;
    inst_t     inst;

    modport src (
        output valid, op, rd_ena, rd_addr, rd_data,
        output ls_sel, ls_addr, store_data, pc, inst
    );

    modport dst (
        input valid, op, rd_ena, rd_addr, rd_data,
        input ls_sel, ls_addr, store_data, pc, inst
    );

endinterface

//--- core_pkg.sv
// Shared types and RV64I encodings for the execute and memory stages.
// XLEN is fixed at 64. Only the listed opcode and funct values are decoded.
package core_pkg;

    // ============================================================
    // widths and vector types
    // ============================================================
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [63:0]     pc_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      ls_sel_t;   // same bits as the instruction funct3.

    // operation class carried down the pipeline.
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_ALU   = 2'd1,
        OP_LOAD  = 2'd2,
        OP_STORE = 2'd3
    } op_e;

    // ============================================================
    // opcodes and function fields
    // ============================================================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;   // add, sub and addi.
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;   // srl only, sra is not decoded.
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // load and store width selects.
    localparam ls_sel_t LS_B  = 3'b000;
    localparam ls_sel_t LS_H  = 3'b001;
    localparam ls_sel_t LS_W  = 3'b010;
    localparam ls_sel_t LS_D  = 3'b011;
    localparam ls_sel_t LS_BU = 3'b100;
    localparam ls_sel_t LS_HU = 3'b101;
    localparam ls_sel_t LS_WU = 3'b110;

endpackage
